//--- rtl/axi_checker_top.sv
module axi_checker_top (
    input  logic                    aclk,
    input  logic                    aresetn,
    // AXI-Lite register access
    input  checker_pkg::lite_addr_t awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  checker_pkg::data_word_t wdata,
    input  logic [3:0]              wstrb,      // Full word writes only
    input  logic                    wvalid,
    output logic                    wready,
    output checker_pkg::resp_t      bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  checker_pkg::lite_addr_t araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output checker_pkg::data_word_t rdata,
    output checker_pkg::resp_t      rresp,
    output logic                    rvalid,
    input  logic                    rready,
    // AXI4 write stream under test
    input  checker_pkg::full_addr_t s_axi_awaddr,
    input  checker_pkg::burst_len_t s_axi_awlen,
    input  logic                    s_axi_awvalid,
    output logic                    s_axi_awready,
    input  checker_pkg::data_word_t s_axi_wdata,
    input  logic                    s_axi_wlast,
    input  logic                    s_axi_wvalid,
    output logic                    s_axi_wready,
    output checker_pkg::resp_t      s_axi_bresp,
    output logic                    s_axi_bvalid,
    input  logic                    s_axi_bready
);

    checker_pkg::data_word_t beat_data;
    logic                    beat_valid;
    logic                    beat_last;
    logic                    checker_ready;
    logic                    soft_reset;
    logic                    enable;
    checker_pkg::count_t     packet_size;
    checker_pkg::count_t     data_errors;
    checker_pkg::count_t     packet_errors;

    burst_sink u_burst_sink (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awlen   (s_axi_awlen),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wlast   (s_axi_wlast),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .checker_ready (checker_ready),
        .beat_data     (beat_data),
        .beat_valid    (beat_valid),
        .beat_last     (beat_last)
    );

    sequence_checker u_sequence_checker (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .soft_reset    (soft_reset),
        .enable        (enable),
        .packet_size   (packet_size),
        .beat_data     (beat_data),
        .beat_valid    (beat_valid),
        .beat_last     (beat_last),
        .checker_ready (checker_ready),
        .data_errors   (data_errors),
        .packet_errors (packet_errors)
    );

    control_regs u_control_regs (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .awaddr        (awaddr),
        .awvalid       (awvalid),
        .awready       (awready),
        .wdata         (wdata),
        .wvalid        (wvalid),
        .wready        (wready),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .bready        (bready),
        .araddr        (araddr),
        .arvalid       (arvalid),
        .arready       (arready),
        .rdata         (rdata),
        .rresp         (rresp),
        .rvalid        (rvalid),
        .rready        (rready),
        .data_errors   (data_errors),
        .packet_errors (packet_errors),
        .soft_reset    (soft_reset),
        .enable        (enable),
        .packet_size   (packet_size)
    );

endmodule

//--- rtl/burst_sink.sv
module burst_sink (
    input  logic                    aclk,
    input  logic                    aresetn,
    // AXI4 write slave
    input  checker_pkg::full_addr_t s_axi_awaddr,
    input  checker_pkg::burst_len_t s_axi_awlen,
    input  logic                    s_axi_awvalid,
    output logic                    s_axi_awready,
    input  checker_pkg::data_word_t s_axi_wdata,
    input  logic                    s_axi_wlast,
    input  logic                    s_axi_wvalid,
    output logic                    s_axi_wready,
    output checker_pkg::resp_t      s_axi_bresp,
    output logic                    s_axi_bvalid,
    input  logic                    s_axi_bready,
    // Beats towards the checker
    input  logic                    checker_ready,
    output checker_pkg::data_word_t beat_data,
    output logic                    beat_valid,
    output logic                    beat_last
);

    checker_pkg::burst_state_t state;

    logic aw_fire;
    logic w_fire;

    // Address and length are taken with the handshake but not interpreted,
    // the burst ends on wlast alone
    assign aw_fire = s_axi_awvalid && s_axi_awready;
    assign w_fire  = s_axi_wvalid && s_axi_wready;

    assign s_axi_wready = (state == checker_pkg::data) && checker_ready;
    assign s_axi_bvalid = (state == checker_pkg::resp);
    assign s_axi_bresp  = checker_pkg::resp_okay;

    assign beat_data  = s_axi_wdata;
    assign beat_valid = w_fire;
    assign beat_last  = s_axi_wlast;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state         <= checker_pkg::idle;
            s_axi_awready <= 1'b0;
        end else begin
            s_axi_awready <= 1'b0;  // Single cycle pulse
            case (state)
                checker_pkg::idle: begin
                    if (aw_fire) begin
                        state <= checker_pkg::data;
                    end else if (s_axi_awvalid && !s_axi_awready && checker_ready) begin
                        s_axi_awready <= 1'b1;
                    end
                end
                checker_pkg::data: begin
                    if (w_fire && s_axi_wlast) begin
                        state <= checker_pkg::resp;
                    end
                end
                checker_pkg::resp: begin
                    if (s_axi_bready) begin
                        state <= checker_pkg::idle;
                    end
                end
                default: state <= checker_pkg::idle;
            endcase
        end
    end

endmodule

//--- rtl/checker_pkg.sv
package checker_pkg;

    // ################################################
    // Widths and types
    // ################################################

    localparam int data_bytes = 4;                  // Bytes per stream beat

    typedef logic [data_bytes*8-1:0] data_word_t;   // Stream beat or register word
    typedef logic [31:0]             count_t;       // Error count or packet size
    typedef logic [5:0]              lite_addr_t;   // AXI-Lite byte address
    typedef logic [19:0]             full_addr_t;   // AXI4 write address
    typedef logic [7:0]              burst_len_t;   // AXI len field
    typedef logic [2:0]              reg_index_t;   // Lite address bits 4:2
    typedef logic [1:0]              resp_t;

    // ################################################
    // Response codes and register map
    // ################################################

    localparam resp_t resp_okay   = 2'd0;
    localparam resp_t resp_slverr = 2'd2;

    localparam reg_index_t reg_ctrl          = 3'd0;
    localparam reg_index_t reg_enable        = 3'd1;
    localparam reg_index_t reg_packet_size   = 3'd2;
    localparam reg_index_t reg_data_errors   = 3'd3;  // Read only
    localparam reg_index_t reg_packet_errors = 3'd4;  // Read only
    localparam reg_index_t reg_info          = 3'd5;  // Read only
    localparam reg_index_t reg_count         = 3'd6;

    // Reset values of the writable registers
    localparam data_word_t ctrl_reset_value    = 32'h0000_0001;  // Checker held in soft reset
    localparam data_word_t enable_reset_value  = 32'h0000_0000;
    localparam count_t     default_packet_size = 32'd16;         // Beats per burst

    // ################################################
    // Burst sink states
    // ################################################

    typedef enum logic [1:0] {
        idle,   // Waiting for an address
        data,   // Taking beats up to wlast
        resp    // Write response pending
    } burst_state_t;

endpackage

//--- rtl/control_regs.sv
module control_regs (
    input  logic                    aclk,
    input  logic                    aresetn,
    // AXI-Lite slave
    input  checker_pkg::lite_addr_t awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  checker_pkg::data_word_t wdata,
    input  logic                    wvalid,
    output logic                    wready,
    output checker_pkg::resp_t      bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  checker_pkg::lite_addr_t araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output checker_pkg::data_word_t rdata,
    output checker_pkg::resp_t      rresp,
    output logic                    rvalid,
    input  logic                    rready,
    // Checker status and control
    input  checker_pkg::count_t     data_errors,
    input  checker_pkg::count_t     packet_errors,
    output logic                    soft_reset,
    output logic                    enable,
    output checker_pkg::count_t     packet_size
);

    checker_pkg::data_word_t ctrl_reg;
    checker_pkg::data_word_t enable_reg;
    checker_pkg::data_word_t read_word;
    checker_pkg::reg_index_t wr_index;
    checker_pkg::reg_index_t rd_index;

    logic write_accept;  // Drives awready and wready together
    logic write_fire;
    logic read_fire;

    assign wr_index   = awaddr[4:2];
    assign rd_index   = araddr[4:2];
    assign awready    = write_accept;
    assign wready     = write_accept;
    assign write_fire = write_accept && awvalid && wvalid;
    assign read_fire  = arready && arvalid;

    assign soft_reset = ctrl_reg[0];
    assign enable     = enable_reg[0];

    // ################################################
    // Write channel
    // ################################################

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            write_accept <= 1'b0;
            bvalid       <= 1'b0;
        end else begin
            write_accept <= !write_accept && awvalid && wvalid && !bvalid;
            if (write_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ctrl_reg    <= checker_pkg::ctrl_reset_value;
            enable_reg  <= checker_pkg::enable_reset_value;
            packet_size <= checker_pkg::default_packet_size;
        end else if (write_fire) begin
            case (wr_index)
                checker_pkg::reg_ctrl:        ctrl_reg    <= wdata;
                checker_pkg::reg_enable:      enable_reg  <= wdata;
                checker_pkg::reg_packet_size: packet_size <= wdata;
                default: ;  // Status words ignore writes
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (write_fire) begin
            bresp <= (wr_index >= checker_pkg::reg_count) ? checker_pkg::resp_slverr
                                                          : checker_pkg::resp_okay;
        end
    end

    // ################################################
    // Read channel
    // ################################################

    always_comb begin
        case (rd_index)
            checker_pkg::reg_ctrl:          read_word = ctrl_reg;
            checker_pkg::reg_enable:        read_word = enable_reg;
            checker_pkg::reg_packet_size:   read_word = packet_size;
            checker_pkg::reg_data_errors:   read_word = data_errors;    // Live counter
            checker_pkg::reg_packet_errors: read_word = packet_errors;
            checker_pkg::reg_info:          read_word = checker_pkg::data_word_t'(checker_pkg::data_bytes);
            default:                        read_word = '0;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= !arready && arvalid && !rvalid;
            if (read_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (read_fire) begin
            rdata <= read_word;
            rresp <= (rd_index >= checker_pkg::reg_count) ? checker_pkg::resp_slverr
                                                          : checker_pkg::resp_okay;
        end
    end

endmodule

//--- rtl/sequence_checker.sv
module sequence_checker (
    input  logic                    aclk,
    input  logic                    aresetn,
    // Control from the register bank
    input  logic                    soft_reset,
    input  logic                    enable,
    input  checker_pkg::count_t     packet_size,
    // Beats from the burst sink
    input  checker_pkg::data_word_t beat_data,
    input  logic                    beat_valid,
    input  logic                    beat_last,
    output logic                    checker_ready,
    // Status back to the register bank
    output checker_pkg::count_t     data_errors,
    output checker_pkg::count_t     packet_errors
);

    checker_pkg::data_word_t expected_word;
    checker_pkg::count_t     beat_count;    // Beats already taken in this burst
    checker_pkg::count_t     burst_beats;   // Including the current beat

    logic clear;

    assign clear         = !aresetn || soft_reset;
    assign checker_ready = enable && !soft_reset;
    assign burst_beats   = beat_count + 32'd1;

    // ################################################
    // Expected word
    // ################################################

    // Advances by one per beat whatever arrived, so a single bad word
    // leaves the following beats in step
    always_ff @(posedge aclk) begin
        if (clear) begin
            expected_word <= '0;
        end else if (beat_valid) begin
            expected_word <= expected_word + 32'd1;
        end
    end

    always_ff @(posedge aclk) begin
        if (clear) begin
            data_errors <= '0;
        end else if (beat_valid && (beat_data != expected_word)) begin
            data_errors <= data_errors + 32'd1;
        end
    end

    // ################################################
    // Burst length
    // ################################################

    always_ff @(posedge aclk) begin
        if (clear) begin
            beat_count <= '0;
        end else if (beat_valid) begin
            if (beat_last) begin
                beat_count <= '0;   // Next burst starts fresh
            end else begin
                beat_count <= burst_beats;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (clear) begin
            packet_errors <= '0;
        end else if (beat_valid && beat_last && (burst_beats != packet_size)) begin
            packet_errors <= packet_errors + 32'd1;
        end
    end

endmodule

//--- sources.f
rtl/checker_pkg.sv
rtl/burst_sink.sv
rtl/sequence_checker.sv
rtl/control_regs.sv
rtl/axi_checker_top.sv
verification/axi_checker_checker.sv
verification/tb_axi_checker.sv

//--- verification/axi_checker_checker.sv
module axi_checker_checker (
    input logic aclk,
    input logic aresetn,
    input logic bvalid,
    input logic rvalid,
    input logic rready,
    input logic s_axi_wready,
    input logic s_axi_bvalid,
    input logic s_axi_bready,
    input logic checker_ready
);

    stream_bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
        else $error("s_axi_bvalid dropped before s_axi_bready");

    lite_rvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    // Beats only flow while the checker can take them
    wready_gated: assert property (@(posedge aclk) disable iff (!aresetn)
        !(s_axi_wready && !checker_ready))
        else $error("s_axi_wready high while checker_ready is low");

    reset_quiet: assert property (@(posedge aclk) !aresetn |=> !bvalid && !s_axi_bvalid)
        else $error("Write response valid in the cycle after reset");

endmodule

bind axi_checker_top axi_checker_checker u_axi_checker_checker (.*);

//--- verification/axi_checker_testdata.txt
# W index value bresp | R index rdata rresp | B start_word beats corrupt_beat (0 for none)
# E test_name | all numbers in hex, corrupt_beat counts from 1
R 0 1 0
R 1 0 0
R 2 10 0
R 3 0 0
R 4 0 0
R 5 4 0
E reset_values
W 2 8 0
R 2 8 0
W 0 0 0
W 1 1 0
R 0 0 0
R 1 1 0
E register_access
B 0 8 0
B 8 8 0
R 3 0 0
R 4 0 0
E clean_traffic
B 10 8 4
R 3 1 0
R 4 0 0
E data_errors
B 18 5 0
R 4 1 0
R 3 1 0
W 0 1 0
W 0 0 0
R 3 0 0
R 4 0 0
E packet_errors
R 7 0 2
W 6 5 2
E address_errors

//--- verification/tb_axi_checker.sv
module tb_axi_checker;

    localparam int clock_period    = 100;
    localparam int cycles_per_line = 200;

    logic                    aclk;
    logic                    aresetn;
    checker_pkg::lite_addr_t awaddr;
    logic                    awvalid;
    logic                    awready;
    checker_pkg::data_word_t wdata;
    logic [3:0]              wstrb;
    logic                    wvalid;
    logic                    wready;
    checker_pkg::resp_t      bresp;
    logic                    bvalid;
    logic                    bready;
    checker_pkg::lite_addr_t araddr;
    logic                    arvalid;
    logic                    arready;
    checker_pkg::data_word_t rdata;
    checker_pkg::resp_t      rresp;
    logic                    rvalid;
    logic                    rready;
    checker_pkg::full_addr_t s_axi_awaddr;
    checker_pkg::burst_len_t s_axi_awlen;
    logic                    s_axi_awvalid;
    logic                    s_axi_awready;
    checker_pkg::data_word_t s_axi_wdata;
    logic                    s_axi_wlast;
    logic                    s_axi_wvalid;
    logic                    s_axi_wready;
    checker_pkg::resp_t      s_axi_bresp;
    logic                    s_axi_bvalid;
    logic                    s_axi_bready;

    int    cycles          = 0;
    int    cycle_limit     = 0;   // Set once the data file is loaded
    int    mismatches      = 0;
    int    test_mismatches = 0;
    int    tests_passed    = 0;
    int    tests_failed    = 0;
    string lines[$];

    axi_checker_top uut (.*);

    initial begin
        aclk = 1'b0;
        forever #(clock_period / 2) aclk = ~aclk;
    end

    // ################################################
    // Watchdog
    // ################################################

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped answering a handshake", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // ################################################
    // Bus tasks
    // ################################################

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s actual 0x%h expected 0x%h", name, actual, expected);
            mismatches++;
            test_mismatches++;
        end
    endtask

    task automatic reg_write(input int index, input logic [31:0] value,
                             input logic [31:0] exp_resp);
        @(posedge aclk);
        awaddr  <= checker_pkg::lite_addr_t'(index << 2);
        awvalid <= 1'b1;
        wdata   <= value;
        wvalid  <= 1'b1;
        do @(posedge aclk); while (!awready);
        check_value("wready", wready, 1'b1);  // Pulses together with awready
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b1;
        do @(posedge aclk); while (!bvalid);
        bready  <= 1'b0;
        check_value($sformatf("bresp[%0d]", index), bresp, exp_resp);
    endtask

    task automatic reg_read(input int index, input logic [31:0] exp_data,
                            input logic [31:0] exp_resp);
        @(posedge aclk);
        araddr  <= checker_pkg::lite_addr_t'(index << 2);
        arvalid <= 1'b1;
        do @(posedge aclk); while (!arready);
        arvalid <= 1'b0;
        rready  <= 1'b1;
        do @(posedge aclk); while (!rvalid);  // rdata is registered, stable here
        rready  <= 1'b0;
        check_value($sformatf("rdata[%0d]", index), rdata, exp_data);
        check_value($sformatf("rresp[%0d]", index), rresp, exp_resp);
    endtask

    // Consecutive words from start_word, the beat at corrupt_pos (from 1) inverted
    task automatic send_burst(input logic [31:0] start_word, input int beats,
                              input int corrupt_pos);
        logic [31:0] word;
        @(posedge aclk);
        s_axi_awaddr  <= '0;
        s_axi_awlen   <= checker_pkg::burst_len_t'(beats - 1);
        s_axi_awvalid <= 1'b1;
        do @(posedge aclk); while (!s_axi_awready);
        s_axi_awvalid <= 1'b0;
        for (int i = 0; i < beats; i++) begin
            word = start_word + i;
            s_axi_wdata  <= (i + 1 == corrupt_pos) ? ~word : word;
            s_axi_wlast  <= (i == beats - 1);
            s_axi_wvalid <= 1'b1;
            do @(posedge aclk); while (!s_axi_wready);
        end
        s_axi_wvalid <= 1'b0;
        s_axi_wlast  <= 1'b0;
        s_axi_bready <= 1'b1;
        do @(posedge aclk); while (!s_axi_bvalid);
        s_axi_bready <= 1'b0;
        check_value("s_axi_bresp", s_axi_bresp, checker_pkg::resp_okay);
    endtask

    task automatic end_test(input string name);
        if (test_mismatches == 0) begin
            tests_passed++;
            $display("Test %s passed", name);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d mismatches", name, test_mismatches);
        end
        test_mismatches = 0;
    endtask

    // ################################################
    // Stimulus
    // ################################################

    initial begin
        int          fd;
        int          fields;
        string       line;
        string       op;
        string       name;
        logic [31:0] arg_a;
        logic [31:0] arg_b;
        logic [31:0] arg_c;

        aresetn       = 1'b0;
        awaddr        = '0;
        awvalid       = 1'b0;
        wdata         = '0;
        wstrb         = 4'hf;
        wvalid        = 1'b0;
        bready        = 1'b0;
        araddr        = '0;
        arvalid       = 1'b0;
        rready        = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awlen   = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wlast   = 1'b0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;

        fd = $fopen("verification/axi_checker_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            mismatches++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0) lines.push_back(line);
            end
            $fclose(fd);
        end
        cycle_limit = cycles_per_line * lines.size();

        repeat (2) @(posedge aclk);
        aresetn <= 1'b1;

        foreach (lines[n]) begin
            if ($sscanf(lines[n], "%s", op) != 1 || op[0] == "#") continue;  // Blank or comment
            fields = $sscanf(lines[n], "%s %h %h %h", op, arg_a, arg_b, arg_c);
            if (op != "E" && fields != 4) begin
                $display("Line %0d of the test data file is malformed", n + 1);
                mismatches++;
                continue;
            end
            case (op)
                "W": reg_write(arg_a, arg_b, arg_c);
                "R": reg_read(arg_a, arg_b, arg_c);
                "B": send_burst(arg_a, arg_b, arg_c);
                "E": begin
                    void'($sscanf(lines[n], "%s %s", op, name));
                    end_test(name);
                end
                default: begin
                    $display("Unknown operation %s in line %0d of the test data file", op, n + 1);
                    mismatches++;
                end
            endcase
        end

        repeat (2) @(posedge aclk);
        $display("Tests passed %0d, tests failed %0d, mismatches %0d",
                 tests_passed, tests_failed, mismatches);
        if (mismatches == 0 && tests_failed == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
